// File: Bender.yml
package:
  name: object_tracker

sources:
  - design/tracker_pkg.sv
  - design/pixel_capture.sv
  - design/blob_accumulator.sv
  - design/centroid_divider.sv
  - design/object_tracker_top.sv
  - target: simulation
    files:
      - dv/tracker_tb.sv

// File: design/blob_accumulator.sv
/* Blob accumulator
   Thresholds pixels and sums object coordinates and count per frame */

`timescale 1ns/1ps
`default_nettype none

module blob_accumulator
(
    input  logic                     D5M_PIXLCLK,
    input  logic                     rst_n,
    input  tracker_pkg::pixel_beat_t beat,
    input  logic                     frame_end,
    input  tracker_pkg::pixel_t      threshold,
    output tracker_pkg::frame_sums_t sums,
    output logic                     sums_valid
);

    // ============================================================
    // Classification
    // ============================================================
    logic                      hit;
    tracker_pkg::sum_x_t       add_x;
    tracker_pkg::sum_y_t       add_y;
    tracker_pkg::pixel_count_t add_cnt;
    // Running totals for the current frame
    tracker_pkg::sum_x_t       acc_x;
    tracker_pkg::sum_y_t       acc_y;
    tracker_pkg::pixel_count_t acc_cnt;
    tracker_pkg::frame_sums_t  next_tot;

    // Bright pixel inside the active area
    assign hit     = beat.valid && (beat.data >= threshold);
    assign add_x   = hit ? tracker_pkg::sum_x_t'(beat.x) : '0;
    assign add_y   = hit ? tracker_pkg::sum_y_t'(beat.y) : '0;
    assign add_cnt = tracker_pkg::pixel_count_t'(hit);

    // Totals including this cycle's pixel
    assign next_tot.sum_x = acc_x + add_x;
    assign next_tot.sum_y = acc_y + add_y;
    assign next_tot.count = acc_cnt + add_cnt;

    // ============================================================
    // Accumulators
    // ============================================================
    always_ff @(posedge D5M_PIXLCLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            acc_x      <= '0;
            acc_y      <= '0;
            acc_cnt    <= '0;
            sums_valid <= 1'b0;
        end
        else
        begin
            sums_valid <= frame_end;
            if (frame_end)
            begin
                // Fresh start for the next frame
                acc_x   <= '0;
                acc_y   <= '0;
                acc_cnt <= '0;
            end
            else
            begin
                acc_x   <= next_tot.sum_x;
                acc_y   <= next_tot.sum_y;
                acc_cnt <= next_tot.count;
            end
        end
    end

    // Frame result, held until the next frame end
    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (frame_end)
            sums <= next_tot;
    end

endmodule

`default_nettype wire

// File: design/centroid_divider.sv
/* Centroid divider
   Two restoring dividers turn frame sums into the object centre */

`timescale 1ns/1ps
`default_nettype none

module centroid_divider
#(
    parameter int MIN_PIXELS = 4
)
(
    input  logic                     D5M_PIXLCLK,
    input  logic                     rst_n,
    input  tracker_pkg::frame_sums_t sums,
    input  logic                     sums_valid,
    output tracker_pkg::centroid_t   cent,
    output logic                     cent_valid,
    output logic                     object_seen
);

    // Dividend width sets the iteration count
    localparam int DW = $bits(tracker_pkg::sum_x_t);
    // Remainder needs one bit over the divisor
    localparam int RW = $bits(tracker_pkg::pixel_count_t) + 1;

    tracker_pkg::div_state_t   state;
    logic [4:0]                iter;
    tracker_pkg::pixel_count_t divisor;
    // Dividend shifts out as the quotient shifts in
    logic [DW-1:0]             dvd_x;
    logic [DW-1:0]             dvd_y;
    logic [RW-1:0]             rem_x;
    logic [RW-1:0]             rem_y;
    logic                      enough;

    // One restoring step, returns {remainder, dividend/quotient}
    function automatic logic [RW+DW-1:0] div_step(
        input logic [RW-1:0]             rem,
        input logic [DW-1:0]             dvd,
        input tracker_pkg::pixel_count_t dvs
    );
        logic [RW-1:0] shifted;
        logic [RW:0]   diff;
        shifted = {rem[RW-2:0], dvd[DW-1]};
        diff    = {1'b0, shifted} - {2'b00, dvs};
        // Negative trial keeps the old remainder
        if (diff[RW])
            div_step = {shifted, dvd[DW-2:0], 1'b0};
        else
            div_step = {diff[RW-1:0], dvd[DW-2:0], 1'b1};
    endfunction

    assign enough = (sums.count >= tracker_pkg::pixel_count_t'(MIN_PIXELS));

    // ============================================================
    // Control FSM and result
    // ============================================================
    always_ff @(posedge D5M_PIXLCLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state       <= tracker_pkg::IDLE;
            iter        <= '0;
            cent        <= '0;
            cent_valid  <= 1'b0;
            object_seen <= 1'b0;
        end
        else
        begin
            cent_valid <= 1'b0;
            case (state)
                tracker_pkg::IDLE:
                begin
                    iter <= '0;
                    if (sums_valid && enough)
                        state <= tracker_pkg::DIVIDE;
                    else if (sums_valid)
                        object_seen <= 1'b0;
                end
                tracker_pkg::DIVIDE:
                begin
                    // Last quotient bit lands this cycle
                    if (iter == 5'(DW - 1))
                        state <= tracker_pkg::DONE;
                    iter <= iter + 1'b1;
                end
                tracker_pkg::DONE:
                begin
                    // Truncated quotients, always inside the frame
                    cent.x      <= tracker_pkg::coord_x_t'(dvd_x);
                    cent.y      <= tracker_pkg::coord_y_t'(dvd_y);
                    cent_valid  <= 1'b1;
                    object_seen <= 1'b1;
                    state       <= tracker_pkg::IDLE;
                end
                default:
                    state <= tracker_pkg::IDLE;
            endcase
        end
    end

    // ============================================================
    // Datapath, both divisions in lockstep
    // ============================================================
    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (state == tracker_pkg::IDLE)
        begin
            divisor <= sums.count;
            dvd_x   <= sums.sum_x;
            dvd_y   <= {1'b0, sums.sum_y};
            rem_x   <= '0;
            rem_y   <= '0;
        end
        else if (state == tracker_pkg::DIVIDE)
        begin
            {rem_x, dvd_x} <= div_step(rem_x, dvd_x, divisor);
            {rem_y, dvd_y} <= div_step(rem_y, dvd_y, divisor);
        end
    end

endmodule

`default_nettype wire

// File: design/object_tracker_top.sv
/* Object tracker top
   Camera capture, blob accumulation and centroid division in the pixel domain */

`timescale 1ns/1ps
`default_nettype none

module object_tracker_top
#(
    // Smallest object that counts as a detection
    parameter int MIN_PIXELS = 4
)
(
    input  logic                      D5M_PIXLCLK,
    input  logic                      rst_n,
    input  tracker_pkg::pixel_t       d5m_d,
    input  logic                      d5m_fval,
    input  logic                      d5m_lval,
    // Static brightness level
    input  tracker_pkg::pixel_t       threshold,
    output tracker_pkg::centroid_t    cent,
    output logic                      cent_valid,
    output logic                      object_seen,
    output tracker_pkg::frame_count_t frame_count
);

    // ============================================================
    // Internal links
    // ============================================================
    tracker_pkg::pixel_beat_t beat;
    logic                     frame_end;
    tracker_pkg::frame_sums_t sums;
    logic                     sums_valid;

    // Sensor bus to coordinates
    pixel_capture u_capture (
        .D5M_PIXLCLK (D5M_PIXLCLK),
        .rst_n       (rst_n),
        .d5m_d       (d5m_d),
        .d5m_fval    (d5m_fval),
        .d5m_lval    (d5m_lval),
        .beat        (beat),
        .frame_end   (frame_end),
        .frame_count (frame_count)
    );

    // Threshold and per-frame totals
    blob_accumulator u_accum (
        .D5M_PIXLCLK (D5M_PIXLCLK),
        .rst_n       (rst_n),
        .beat        (beat),
        .frame_end   (frame_end),
        .threshold   (threshold),
        .sums        (sums),
        .sums_valid  (sums_valid)
    );

    // Mean position of the object
    centroid_divider #(
        .MIN_PIXELS  (MIN_PIXELS)
    ) u_divider (
        .D5M_PIXLCLK (D5M_PIXLCLK),
        .rst_n       (rst_n),
        .sums        (sums),
        .sums_valid  (sums_valid),
        .cent        (cent),
        .cent_valid  (cent_valid),
        .object_seen (object_seen)
    );

endmodule

`default_nettype wire

// File: design/pixel_capture.sv
/* Pixel capture
   Registers the D5M bus, frames pixels into x/y and counts frames */

`timescale 1ns/1ps
`default_nettype none

module pixel_capture
(
    input  logic                      D5M_PIXLCLK,
    input  logic                      rst_n,
    input  tracker_pkg::pixel_t       d5m_d,
    input  logic                      d5m_fval,
    input  logic                      d5m_lval,
    output tracker_pkg::pixel_beat_t  beat,
    output logic                      frame_end,
    output tracker_pkg::frame_count_t frame_count
);

    // ============================================================
    // Input register stage
    // ============================================================
    tracker_pkg::pixel_t   d_r;
    logic                  fval_r;
    logic                  lval_r;
    // One more stage of the strobes for edge detection
    logic                  fval_d;
    logic                  lval_d;
    tracker_pkg::coord_x_t x_cnt;
    tracker_pkg::coord_y_t y_cnt;
    logic                  pix_ok;
    logic                  lval_fall;
    logic                  fval_fall;

    // Sample data carries no reset
    always_ff @(posedge D5M_PIXLCLK)
    begin
        d_r <= d5m_d;
    end

    always_ff @(posedge D5M_PIXLCLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            fval_r <= 1'b0;
            lval_r <= 1'b0;
            fval_d <= 1'b0;
            lval_d <= 1'b0;
        end
        else
        begin
            fval_r <= d5m_fval;
            lval_r <= d5m_lval;
            fval_d <= fval_r;
            lval_d <= lval_r;
        end
    end

    // Pixel only counts inside both frame and line
    assign pix_ok    = fval_r & lval_r;
    assign lval_fall = lval_d & ~lval_r;
    assign fval_fall = fval_d & ~fval_r;

    // ============================================================
    // Coordinates, beat and frame strobe
    // ============================================================
    always_ff @(posedge D5M_PIXLCLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            beat        <= '0;
            x_cnt       <= '0;
            y_cnt       <= '0;
            frame_end   <= 1'b0;
            frame_count <= '0;
        end
        else
        begin
            beat.valid <= pix_ok;
            beat.data  <= d_r;
            beat.x     <= x_cnt;
            beat.y     <= y_cnt;
            frame_end  <= fval_fall;
            // Column restarts whenever the line is low
            if (pix_ok)
                x_cnt <= x_cnt + 1'b1;
            else if (!lval_r)
                x_cnt <= '0;
            // Frame end wins over a late line fall
            if (frame_end)
                y_cnt <= '0;
            else if (lval_fall && fval_r)
                y_cnt <= y_cnt + 1'b1;
            // Wraps at 16 bits
            if (fval_fall)
                frame_count <= frame_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: design/tracker_pkg.sv
/* Object tracker shared types
   Pixel and coordinate widths, per-frame sums and divider states */

`default_nettype none

package tracker_pkg;

    // ============================================================
    // Scalar widths
    // ============================================================
    // Raw D5M sample, also used for the threshold level
    typedef logic [11:0] pixel_t;
    // Column within an active line
    typedef logic [9:0]  coord_x_t;
    // Line within a frame
    typedef logic [8:0]  coord_y_t;
    // Completed frames, wraps
    typedef logic [15:0] frame_count_t;
    // Object pixels in one frame
    typedef logic [18:0] pixel_count_t;
    // Coordinate sums, sized for a full 640x480 frame
    typedef logic [27:0] sum_x_t;
    typedef logic [26:0] sum_y_t;

    // ============================================================
    // Bundles
    // ============================================================
    // One captured pixel with its position
    typedef struct packed {
        logic     valid;
        pixel_t   data;
        coord_x_t x;
        coord_y_t y;
    } pixel_beat_t;

    // Totals over the object pixels of one frame
    typedef struct packed {
        sum_x_t       sum_x;
        sum_y_t       sum_y;
        pixel_count_t count;
    } frame_sums_t;

    // Object centre
    typedef struct packed {
        coord_x_t x;
        coord_y_t y;
    } centroid_t;

    // Sequential divider FSM
    typedef enum logic [1:0] {
        IDLE,
        DIVIDE,
        DONE
    } div_state_t;

endpackage

`default_nettype wire

// File: dv/tracker_tb.sv
/* Object tracker testbench
   Random frames through the DUT, centroids checked against a frame model */

`timescale 1ns/1ps
`default_nettype none

module tracker_tb;

    // ============================================================
    // Run setup
    // ============================================================
    localparam int CLK_PERIOD = 200;
    localparam int NUM_FRAMES = 24;
    localparam int MIN_PIXELS = 4;
    // Window for the result after fval drops
    localparam int WAIT_CYCLES = 40;

    logic                      D5M_PIXLCLK;
    logic                      rst_n;
    tracker_pkg::pixel_t       d5m_d;
    logic                      d5m_fval;
    logic                      d5m_lval;
    tracker_pkg::pixel_t       threshold;
    tracker_pkg::centroid_t    cent;
    logic                      cent_valid;
    logic                      object_seen;
    tracker_pkg::frame_count_t frame_count;

    // Model state for the frame in flight
    int                        m_cnt;
    longint                    m_sx;
    longint                    m_sy;
    int                        frames_sent;
    tracker_pkg::centroid_t    prev_cent;

    object_tracker_top #(
        .MIN_PIXELS  (MIN_PIXELS)
    ) DUT (
        .D5M_PIXLCLK (D5M_PIXLCLK),
        .rst_n       (rst_n),
        .d5m_d       (d5m_d),
        .d5m_fval    (d5m_fval),
        .d5m_lval    (d5m_lval),
        .threshold   (threshold),
        .cent        (cent),
        .cent_valid  (cent_valid),
        .object_seen (object_seen),
        .frame_count (frame_count)
    );

    initial
    begin
        D5M_PIXLCLK = 1'b0;
        forever #(CLK_PERIOD / 2) D5M_PIXLCLK = ~D5M_PIXLCLK;
    end

    // Budget of 1000 cycles per frame
    initial
    begin
        #(NUM_FRAMES * 1000 * CLK_PERIOD);
        $display("Watchdog expired before all frames were checked");
        $display("RESULT: FAIL");
        $fatal(1, "Run stopped by watchdog");
    end

    // ============================================================
    // Failure reporting and compare tasks
    // ============================================================
    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "Run stopped on first error");
    endtask

    task automatic check_centroid(input string name, input tracker_pkg::centroid_t exp,
                                  input tracker_pkg::centroid_t act);
        if (exp !== act)
            stop_run($sformatf("MISMATCH %s expected x=%0d y=%0d actual x=%0d y=%0d",
                               name, exp.x, exp.y, act.x, act.y));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act)
            stop_run($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
    endtask

    task automatic check_frames(input string name, input tracker_pkg::frame_count_t exp,
                                input tracker_pkg::frame_count_t act);
        if (exp !== act)
            stop_run($sformatf("MISMATCH %s expected %0d actual %0d", name, exp, act));
    endtask

    // ============================================================
    // Stimulus helpers
    // ============================================================
    // Bus changes only on the falling edge
    task automatic drive_bus(input logic f, input logic l, input tracker_pkg::pixel_t d);
        @(negedge D5M_PIXLCLK);
        d5m_fval = f;
        d5m_lval = l;
        d5m_d    = d;
    endtask

    function automatic tracker_pkg::pixel_t bright_pixel();
        return tracker_pkg::pixel_t'(threshold + $urandom % (4096 - threshold));
    endfunction

    function automatic tracker_pkg::pixel_t dark_pixel();
        return tracker_pkg::pixel_t'($urandom % threshold);
    endfunction

    // About one pixel in five is bright
    // Dim frames stop below MIN_PIXELS
    function automatic tracker_pkg::pixel_t pick_pixel(input logic dim, input int cnt);
        if (dim && cnt >= MIN_PIXELS - 1)
            return dark_pixel();
        if ($urandom % 5 == 0)
            return bright_pixel();
        return dark_pixel();
    endfunction

    // Active part of one frame
    // Model follows each driven pixel
    task automatic send_frame(input logic dim);
        int                  lines;
        int                  width;
        tracker_pkg::pixel_t pix;
        lines = 4 + $urandom % 9;
        m_cnt = 0;
        m_sx  = 0;
        m_sy  = 0;
        drive_bus(1'b1, 1'b0, dark_pixel());
        for (int ln = 0; ln < lines; ln++)
        begin
            width = 16 + $urandom % 25;
            for (int px = 0; px < width; px++)
            begin
                pix = pick_pixel(dim, m_cnt);
                drive_bus(1'b1, 1'b1, pix);
                if (pix >= threshold)
                begin
                    m_cnt++;
                    m_sx += px;
                    m_sy += ln;
                end
            end
            // Bright data in the line gap must be ignored
            repeat (1 + $urandom % 4)
                drive_bus(1'b1, 1'b0, bright_pixel());
        end
    endtask

    // Blanking with a stray line pulse
    // Result checks at its end
    task automatic finish_frame(input int idx);
        int                     blank;
        int                     pulses;
        logic                   exp_seen;
        tracker_pkg::centroid_t got;
        tracker_pkg::centroid_t exp;
        blank  = 48 + $urandom % 16;
        pulses = 0;
        got    = '0;
        for (int cyc = 0; cyc < blank; cyc++)
        begin
            if (cyc >= 20 && cyc < 24)
                drive_bus(1'b0, 1'b1, bright_pixel());
            else
                drive_bus(1'b0, 1'b0, dark_pixel());
            if (cyc < WAIT_CYCLES && cent_valid)
            begin
                pulses++;
                got = cent;
            end
        end
        exp_seen = (m_cnt >= MIN_PIXELS);
        if (exp_seen)
        begin
            if (pulses == 0)
                stop_run($sformatf("Frame %0d gave no cent_valid within %0d cycles",
                                   idx, WAIT_CYCLES));
            if (pulses > 1)
                stop_run($sformatf("Frame %0d gave %0d cent_valid pulses", idx, pulses));
            exp.x = tracker_pkg::coord_x_t'(m_sx / m_cnt);
            exp.y = tracker_pkg::coord_y_t'(m_sy / m_cnt);
            check_centroid($sformatf("frame %0d centroid", idx), exp, got);
            prev_cent = exp;
        end
        else
        begin
            check_flag($sformatf("frame %0d cent_valid", idx), 1'b0, pulses != 0);
            check_centroid($sformatf("frame %0d held centroid", idx), prev_cent, cent);
        end
        check_flag($sformatf("frame %0d object_seen", idx), exp_seen, object_seen);
        frames_sent++;
        check_frames($sformatf("frame %0d frame_count", idx),
                     tracker_pkg::frame_count_t'(frames_sent), frame_count);
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial
    begin
        rst_n       = 1'b0;
        d5m_d       = '0;
        d5m_fval    = 1'b0;
        d5m_lval    = 1'b0;
        // Seeds the generator and picks the threshold
        threshold   = tracker_pkg::pixel_t'(512 + $urandom(32'hc1fc0829) % 3072);
        frames_sent = 0;
        prev_cent   = '0;
        m_cnt       = 0;
        m_sx        = 0;
        m_sy        = 0;
        repeat (8) @(negedge D5M_PIXLCLK);
        check_flag("reset cent_valid", 1'b0, cent_valid);
        check_flag("reset object_seen", 1'b0, object_seen);
        check_frames("reset frame_count", '0, frame_count);
        check_centroid("reset centroid", '0, cent);
        repeat (8) @(negedge D5M_PIXLCLK);
        rst_n = 1'b1;
        @(negedge D5M_PIXLCLK);
        check_flag("post reset cent_valid", 1'b0, cent_valid);
        check_flag("post reset object_seen", 1'b0, object_seen);
        check_frames("post reset frame_count", '0, frame_count);
        check_centroid("post reset centroid", '0, cent);
        // Every fourth frame is kept dim
        for (int f = 0; f < NUM_FRAMES; f++)
        begin
            send_frame(f % 4 == 3);
            finish_frame(f);
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
design/tracker_pkg.sv
design/pixel_capture.sv
design/blob_accumulator.sv
design/centroid_divider.sv
design/object_tracker_top.sv
dv/tracker_tb.sv
